// File: bench/periph_testdata.txt
// Columns: op adr dat sel exp, hex. Ops 1 write, 2 read and expect, 3 inputs (dat = sw<<8 | btn),
// 4 wait dat cycles, 5 LEDs, 6 irq vector {timer_n,gpio_n}, 7 display for dat cycles, 0 end
// GPIO output write, readback, LEDs, partial byte select
1 E0040004 12345678 F 0
2 E0040004 0 0 12345678
5 0 0 0 78
1 E0040004 AABBCCDD 6 0
2 E0040004 0 0 12BBCC78
5 0 0 0 78
// Buttons through switch 1
3 0 00000205 0 0
4 0 2 0 0
2 E0040000 0 0 00000500
3 0 00000005 0 0
4 0 2 0 0
2 E0040000 0 0 0
// GPIO interrupt under the mask
3 0 00000205 0 0
1 E0040008 00000F00 F 0
4 0 3 0 0
6 0 0 0 2
1 E0040008 0 F 0
4 0 3 0 0
6 0 0 0 3
// One-shot timer to compare 20
1 E0020004 14 F 0
1 E0020000 1 F 0
4 0 1E 0 0
2 E0020000 0 0 4
2 E0020008 0 0 14
6 0 0 0 1
1 E0020000 4 F 0
6 0 0 0 3
// Display of A5E3, font bytes A 5 E 3
1 E0040004 0000A5E3 F 0
4 0 3 0 0
7 0 10 0 08120630
5 0 0 0 E3
// Unmapped read then a mapped read
2 00001000 0 0 0
2 E0040004 0 0 0000A5E3
0 0 0 0 0

// File: sim.f
hw/soc_bus_pkg.sv
hw/board_io_pkg.sv
hw/periph_decode.sv
hw/gpio_port.sv
hw/tick_timer.sv
hw/sevenseg_scan.sv
hw/periph_top.sv
bench/periph_tb.sv

// File: Bender.yml
package:
  name: periph_io

sources:
  - files:
      - hw/soc_bus_pkg.sv
      - hw/board_io_pkg.sv
      - hw/periph_decode.sv
      - hw/gpio_port.sv
      - hw/tick_timer.sv
      - hw/sevenseg_scan.sv
      - hw/periph_top.sv
  - target: simulation
    files:
      - bench/periph_tb.sv

// File: bench/periph_tb.sv
//----------------------------
// Testbench for the peripheral block
// Plays the operations of the test data file as the Wishbone master
//----------------------------
`timescale 1ns/100ps

module periph_tb;

	localparam int MAX_WORDS = 320;

	// Operation codes in the first column of the data file
	localparam int OP_END     = 0;
	localparam int OP_WRITE   = 1;
	localparam int OP_READ    = 2;
	localparam int OP_INPUTS  = 3;
	localparam int OP_WAIT    = 4;
	localparam int OP_LED     = 5;
	localparam int OP_IRQ     = 6;
	localparam int OP_DISPLAY = 7;

	logic clk = 1'b0;
	logic rst_n;
	soc_bus_pkg::wb_req_t   req;
	soc_bus_pkg::wb_rsp_t   rsp;
	board_io_pkg::btn_t     btn;
	board_io_pkg::sw_t      sw;
	board_io_pkg::led_t     led;
	board_io_pkg::seg_t     seg;
	board_io_pkg::anode_t   an;
	board_io_pkg::irq_vec_t irq_n;

	// Five words per operation
	logic [31:0] ops [MAX_WORDS];
	int cycles = 0;
	int limit  = 200;

	periph_top #(
		.scan_div (2)
	) periph_top_i (
		.clk_i    (clk),
		.rst_n_i  (rst_n),
		.wb_req_i (req),
		.wb_rsp_o (rsp),
		.btn_i    (btn),
		.sw_i     (sw),
		.led_o    (led),
		.seg_o    (seg),
		.an_o     (an),
		.irq_n_o  (irq_n)
	);

	// 100 ns clock
	always #50 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	//----------------------------
	// Compare tasks
	//----------------------------
	task automatic check_dat(input soc_bus_pkg::wb_dat_t got, input soc_bus_pkg::wb_dat_t exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("ERR %0t: %s returned %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_led(input board_io_pkg::led_t got, input board_io_pkg::led_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t: LEDs show %h, expected %h", $time, got, exp));
	endtask

	task automatic check_seg(input board_io_pkg::seg_t got, input board_io_pkg::seg_t exp,
		input int digit);
		if (got !== exp)
			abort_run($sformatf("ERR %0t: digit %0d segments %b, expected %b",
				$time, digit, got, exp));
	endtask

	task automatic check_irq(input board_io_pkg::irq_vec_t got,
		input board_io_pkg::irq_vec_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t: interrupt vector %b, expected %b", $time, got, exp));
	endtask

	//----------------------------
	// Bus master
	//----------------------------
	// Ack is sampled on the falling edge
	task automatic wait_ack();
		do
			@(negedge clk);
		while (rsp.ack !== 1'b1);
	endtask

	task automatic bus_write(input soc_bus_pkg::wb_adr_t adr, input soc_bus_pkg::wb_dat_t dat,
		input soc_bus_pkg::wb_sel_t sel);
		@(posedge clk);
		req.adr <= adr;
		req.dat <= dat;
		req.sel <= sel;
		req.we  <= 1'b1;
		req.cyc <= 1'b1;
		req.stb <= 1'b1;
		wait_ack();
		// Drop the strobe in the cycle after ack
		@(posedge clk);
		req.cyc <= 1'b0;
		req.stb <= 1'b0;
		req.we  <= 1'b0;
	endtask

	task automatic bus_read(input soc_bus_pkg::wb_adr_t adr, output soc_bus_pkg::wb_dat_t dat);
		@(posedge clk);
		req.adr <= adr;
		req.sel <= 4'hf;
		req.we  <= 1'b0;
		req.cyc <= 1'b1;
		req.stb <= 1'b1;
		wait_ack();
		dat = rsp.dat;
		@(posedge clk);
		req.cyc <= 1'b0;
		req.stb <= 1'b0;
	endtask

	task automatic set_inputs(input board_io_pkg::btn_t b, input board_io_pkg::sw_t s);
		@(posedge clk);
		btn <= b;
		sw  <= s;
	endtask

	// Expected patterns packed one byte per digit, digit 0 lowest
	task automatic watch_display(input int n, input logic [31:0] exp_segs);
		int d;
		logic [3:0] seen;
		seen = '0;
		repeat (n)
		begin
			@(negedge clk);
			d = -1;
			case (an)
				4'b1110: d = 0;
				4'b1101: d = 1;
				4'b1011: d = 2;
				4'b0111: d = 3;
				4'b1111: d = -1;
				default: abort_run($sformatf("Anodes %b are not one-hot at %0t", an, $time));
			endcase
			if (d >= 0)
			begin
				seen[d] = 1'b1;
				check_seg(seg, board_io_pkg::seg_t'(exp_segs[8*d +: 7]), d);
			end
		end
		// Every digit must come up within the window
		if (seen != 4'b1111)
			abort_run($sformatf("Display check saw only digits %b lit, not all four", seen));
	endtask

	// Run limit, checked every clock
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
			abort_run($sformatf("Timeout after %0d cycles with the sequence unfinished", cycles));
	end

	//----------------------------
	// Test sequence
	//----------------------------
	initial
	begin
		soc_bus_pkg::wb_dat_t rdat;
		int pc;
		int i;
		req   <= '0;
		btn   <= '0;
		sw    <= '0;
		rst_n <= 1'b0;
		for (i = 0; i < MAX_WORDS; i++)
			ops[i] = '0;
		$readmemh("bench/periph_testdata.txt", ops);
		// Waits plus four cycles per bus operation
		pc = 0;
		while (pc < MAX_WORDS && ops[pc] != OP_END)
		begin
			case (ops[pc])
				OP_WRITE, OP_READ:   limit += 4;
				OP_WAIT, OP_DISPLAY: limit += ops[pc + 2];
				default:             limit += 0;
			endcase
			pc += 5;
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		pc = 0;
		while (pc < MAX_WORDS && ops[pc] != OP_END)
		begin
			case (ops[pc])
				OP_WRITE:   bus_write(ops[pc + 1], ops[pc + 2], ops[pc + 3][3:0]);
				OP_READ:
				begin
					bus_read(ops[pc + 1], rdat);
					check_dat(rdat, ops[pc + 4], $sformatf("read of %h", ops[pc + 1]));
				end
				OP_INPUTS:  set_inputs(ops[pc + 2][3:0], ops[pc + 2][15:8]);
				OP_WAIT:    repeat (ops[pc + 2]) @(posedge clk);
				OP_LED:
				begin
					@(negedge clk);
					check_led(led, ops[pc + 4][7:0]);
				end
				OP_IRQ:
				begin
					@(negedge clk);
					check_irq(irq_n, board_io_pkg::irq_vec_t'(ops[pc + 4][1:0]));
				end
				OP_DISPLAY: watch_display(ops[pc + 2], ops[pc + 4]);
				default:    abort_run($sformatf("Unknown operation %h in the test data", ops[pc]));
			endcase
			pc += 5;
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: hw/periph_top.sv
//----------------------------
// Peripheral block top level with one Wishbone slave port
// Wires decoder, GPIO, timer and display scanner to the board pins
//----------------------------
`timescale 1ns/100ps

module periph_top
#(
	parameter int scan_div = 4
)
(
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  soc_bus_pkg::wb_req_t   wb_req_i,
	output soc_bus_pkg::wb_rsp_t   wb_rsp_o,
	input  board_io_pkg::btn_t     btn_i,
	input  board_io_pkg::sw_t      sw_i,
	output board_io_pkg::led_t     led_o,
	output board_io_pkg::seg_t     seg_o,
	output board_io_pkg::anode_t   an_o,
	output board_io_pkg::irq_vec_t irq_n_o
);

	soc_bus_pkg::wb_req_t gpio_req;
	soc_bus_pkg::wb_req_t tmr_req;
	soc_bus_pkg::wb_rsp_t gpio_rsp;
	soc_bus_pkg::wb_rsp_t tmr_rsp;
	soc_bus_pkg::wb_dat_t gpio_out;
	logic gpio_irq;
	logic tmr_irq;

	//----------------------------
	// Bus side
	//----------------------------
	periph_decode periph_decode_i (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.req_i      (wb_req_i),
		.gpio_req_o (gpio_req),
		.tmr_req_o  (tmr_req),
		.gpio_rsp_i (gpio_rsp),
		.tmr_rsp_i  (tmr_rsp),
		.rsp_o      (wb_rsp_o)
	);

	gpio_port gpio_port_i (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.req_i      (gpio_req),
		.rsp_o      (gpio_rsp),
		.btn_i      (btn_i),
		.sw_i       (sw_i),
		.gpio_out_o (gpio_out),
		.irq_o      (gpio_irq)
	);

	tick_timer tick_timer_i (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.req_i   (tmr_req),
		.rsp_o   (tmr_rsp),
		.irq_o   (tmr_irq)
	);

	//----------------------------
	// Board side
	//----------------------------
	sevenseg_scan #(
		.scan_div (scan_div)
	) sevenseg_scan_i (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.value_i (gpio_out),
		.seg_o   (seg_o),
		.an_o    (an_o)
	);

	// LEDs show the low byte of the GPIO output
	assign led_o = gpio_out[7:0];

	// Active-low interrupt vector
	assign irq_n_o.timer_n = ~tmr_irq;
	assign irq_n_o.gpio_n  = ~gpio_irq;

endmodule

// File: hw/sevenseg_scan.sv
//----------------------------
// Four-digit multiplexed display scanner
// Shows the low 16 bits of value_i, digit 0 on the rightmost anode
//----------------------------
`timescale 1ns/100ps

module sevenseg_scan
#(
	parameter int scan_div = 4
)
(
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  soc_bus_pkg::wb_dat_t   value_i,
	output board_io_pkg::seg_t     seg_o,
	output board_io_pkg::anode_t   an_o
);

	localparam int PW = $clog2(scan_div + 1);
	localparam logic [PW-1:0] PRESC_LAST = PW'(scan_div - 1);

	typedef enum logic {
		ST_BLANK,
		ST_SCAN
	} scan_state_t;

	scan_state_t state_q;
	logic [PW-1:0] presc_q;
	logic [1:0] digit_q;
	logic [1:0] digit_nxt;
	board_io_pkg::hex_digit_t nibble;
	board_io_pkg::seg_t seg_q;
	board_io_pkg::anode_t an_q;

	// Step to the next digit at the end of each period
	assign digit_nxt = (state_q == ST_SCAN && presc_q == PRESC_LAST) ? digit_q + 2'd1 : digit_q;
	assign nibble    = value_i[{digit_nxt, 2'b00} +: 4];

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= ST_BLANK;
			presc_q <= '0;
			digit_q <= 2'd0;
			seg_q   <= '1;
			an_q    <= '1;
		end
		else
		begin
			// Blank one cycle after reset, then scan for good
			state_q <= ST_SCAN;
			if (state_q == ST_SCAN)
				presc_q <= (presc_q == PRESC_LAST) ? '0 : presc_q + 1'b1;
			digit_q <= digit_nxt;
			// Anode and pattern change on the same edge
			an_q    <= ~(4'b0001 << digit_nxt);
			seg_q   <= board_io_pkg::SEG_FONT[nibble];
		end
	end

	assign seg_o = seg_q;
	assign an_o  = an_q;

endmodule

// File: hw/tick_timer.sv
//----------------------------
// Compare timer slave with enable, auto-reload and sticky pending
// Write one to the pending bit to clear it
//----------------------------
`timescale 1ns/100ps

module tick_timer
(
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  soc_bus_pkg::wb_req_t req_i,
	output soc_bus_pkg::wb_rsp_t rsp_o,
	output logic                 irq_o
);

	soc_bus_pkg::wb_dat_t cmp_q;
	soc_bus_pkg::wb_dat_t cnt_q;
	soc_bus_pkg::wb_dat_t rdat_q;
	soc_bus_pkg::wb_dat_t ctrl_rd;
	soc_bus_pkg::reg_idx_t idx;
	logic en_q;
	logic auto_q;
	logic pend_q;
	logic ack_q;
	logic access;
	logic ctrl_wr;
	logic hit;

	assign idx     = req_i.adr[3:2];
	assign access  = req_i.cyc & req_i.stb & ~ack_q;
	// Control bits live in byte lane 0
	assign ctrl_wr = access & req_i.we & req_i.sel[0] & (idx == soc_bus_pkg::TMR_REG_CTRL);
	// Match while running
	assign hit     = en_q & (cnt_q == cmp_q);

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ack_q  <= 1'b0;
			en_q   <= 1'b0;
			auto_q <= 1'b0;
			pend_q <= 1'b0;
			cmp_q  <= '0;
			cnt_q  <= '0;
		end
		else
		begin
			ack_q <= access;
			if (ctrl_wr)
				auto_q <= req_i.dat[soc_bus_pkg::TMR_CTRL_AUTO];
			// Software enable, or stop after a one-shot match
			if (ctrl_wr)
				en_q <= req_i.dat[soc_bus_pkg::TMR_CTRL_EN];
			else if (hit && !auto_q)
				en_q <= 1'b0;
			// Match wins over a clear in the same cycle
			if (hit)
				pend_q <= 1'b1;
			else if (ctrl_wr && req_i.dat[soc_bus_pkg::TMR_CTRL_PEND])
				pend_q <= 1'b0;
			if (access && req_i.we && idx == soc_bus_pkg::TMR_REG_CMP)
				cmp_q <= soc_bus_pkg::wb_merge(cmp_q, req_i.dat, req_i.sel);
			// Counter, bus write first, then reload or step
			if (access && req_i.we && idx == soc_bus_pkg::TMR_REG_CNT)
				cnt_q <= soc_bus_pkg::wb_merge(cnt_q, req_i.dat, req_i.sel);
			else if (hit)
			begin
				if (auto_q)
					cnt_q <= '0;
			end
			else if (en_q)
				cnt_q <= cnt_q + 32'd1;
		end
	end

	// Control word as seen by a read
	always_comb
	begin
		ctrl_rd = '0;
		ctrl_rd[soc_bus_pkg::TMR_CTRL_EN]   = en_q;
		ctrl_rd[soc_bus_pkg::TMR_CTRL_AUTO] = auto_q;
		ctrl_rd[soc_bus_pkg::TMR_CTRL_PEND] = pend_q;
	end

	always_ff @(posedge clk_i)
	begin
		if (access)
		begin
			case (idx)
				soc_bus_pkg::TMR_REG_CTRL: rdat_q <= ctrl_rd;
				soc_bus_pkg::TMR_REG_CMP:  rdat_q <= cmp_q;
				soc_bus_pkg::TMR_REG_CNT:  rdat_q <= cnt_q;
				default:                   rdat_q <= '0;
			endcase
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = rdat_q;
	// Interrupt is the pending flag itself
	assign irq_o     = pend_q;

endmodule

// File: hw/gpio_port.sv
//----------------------------
// GPIO slave with input, output and interrupt-mask registers
// Buttons reach the input register only while switch 1 is on
//----------------------------
`timescale 1ns/100ps

module gpio_port
(
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  soc_bus_pkg::wb_req_t req_i,
	output soc_bus_pkg::wb_rsp_t rsp_o,
	input  board_io_pkg::btn_t   btn_i,
	input  board_io_pkg::sw_t    sw_i,
	output soc_bus_pkg::wb_dat_t gpio_out_o,
	output logic                 irq_o
);

	soc_bus_pkg::wb_dat_t in_q;
	soc_bus_pkg::wb_dat_t out_q;
	soc_bus_pkg::wb_dat_t mask_q;
	soc_bus_pkg::wb_dat_t rdat_q;
	soc_bus_pkg::reg_idx_t idx;
	logic ack_q;
	logic access;
	logic irq_q;

	assign idx    = req_i.adr[3:2];
	// New access only when not acking already
	assign access = req_i.cyc & req_i.stb & ~ack_q;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ack_q  <= 1'b0;
			in_q   <= '0;
			out_q  <= '0;
			mask_q <= '0;
			irq_q  <= 1'b0;
		end
		else
		begin
			ack_q <= access;
			// Buttons in bits 11 to 8 under switch 1
			in_q  <= sw_i[1] ? {20'b0, btn_i, 8'b0} : '0;
			// Level interrupt on any masked input bit
			irq_q <= |(in_q & mask_q);
			if (access && req_i.we)
			begin
				if (idx == soc_bus_pkg::GPIO_REG_OUT)
					out_q <= soc_bus_pkg::wb_merge(out_q, req_i.dat, req_i.sel);
				if (idx == soc_bus_pkg::GPIO_REG_MASK)
					mask_q <= soc_bus_pkg::wb_merge(mask_q, req_i.dat, req_i.sel);
			end
		end
	end

	// Read data captured with the ack
	always_ff @(posedge clk_i)
	begin
		if (access)
		begin
			case (idx)
				soc_bus_pkg::GPIO_REG_IN:   rdat_q <= in_q;
				soc_bus_pkg::GPIO_REG_OUT:  rdat_q <= out_q;
				soc_bus_pkg::GPIO_REG_MASK: rdat_q <= mask_q;
				default:                    rdat_q <= '0;
			endcase
		end
	end

	assign rsp_o.ack  = ack_q;
	assign rsp_o.dat  = rdat_q;
	assign gpio_out_o = out_q;
	assign irq_o      = irq_q;

endmodule

// File: hw/periph_decode.sv
//----------------------------
// Peripheral address decoder on the Wishbone slave port
// Gates the strobe per region, acks unmapped regions with zero data
//----------------------------
`timescale 1ns/100ps

module periph_decode
(
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  soc_bus_pkg::wb_req_t req_i,
	output soc_bus_pkg::wb_req_t gpio_req_o,
	output soc_bus_pkg::wb_req_t tmr_req_o,
	input  soc_bus_pkg::wb_rsp_t gpio_rsp_i,
	input  soc_bus_pkg::wb_rsp_t tmr_rsp_i,
	output soc_bus_pkg::wb_rsp_t rsp_o
);

	soc_bus_pkg::region_t region;
	logic gpio_hit;
	logic tmr_hit;
	logic miss_ack_q;

	// Region field of the byte address
	assign region   = req_i.adr[31:17];
	assign gpio_hit = (region == soc_bus_pkg::REGION_GPIO);
	assign tmr_hit  = (region == soc_bus_pkg::REGION_TIMER);

	// Same request to both slaves, only stb qualified
	always_comb
	begin
		gpio_req_o     = req_i;
		gpio_req_o.stb = req_i.stb & gpio_hit;
		tmr_req_o      = req_i;
		tmr_req_o.stb  = req_i.stb & tmr_hit;
	end

	//----------------------------
	// Acker for unmapped regions
	//----------------------------
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			miss_ack_q <= 1'b0;
		end
		else
		begin
			// One cycle late, never twice in a row
			miss_ack_q <= req_i.cyc & req_i.stb & ~gpio_hit & ~tmr_hit & ~miss_ack_q;
		end
	end

	// Return path, data follows whichever slave acks
	always_comb
	begin
		rsp_o.ack = gpio_rsp_i.ack | tmr_rsp_i.ack | miss_ack_q;
		if (gpio_rsp_i.ack)
			rsp_o.dat = gpio_rsp_i.dat;
		else if (tmr_rsp_i.ack)
			rsp_o.dat = tmr_rsp_i.dat;
		else
			rsp_o.dat = '0;
	end

endmodule

// File: hw/board_io_pkg.sv
//----------------------------
// Board-facing types for display, LEDs, buttons, switches and interrupts
// Also holds the hex font used by the display scanner
//----------------------------
package board_io_pkg;

	// One display digit
	typedef logic [3:0] hex_digit_t;

	// Segments active low, bit 0 is segment a
	typedef logic [6:0] seg_t;

	// Anodes active low, one-hot while scanning
	typedef logic [3:0] anode_t;

	// Board LEDs, push buttons and slide switches
	typedef logic [7:0] led_t;
	typedef logic [3:0] btn_t;
	typedef logic [7:0] sw_t;

	// Interrupt lines to the CPU side, active low
	typedef struct packed {
		logic timer_n;
		logic gpio_n;
	} irq_vec_t;

	//----------------------------
	// Hex font, index is the nibble value
	//----------------------------
	localparam seg_t SEG_FONT [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

endpackage

// File: hw/soc_bus_pkg.sv
//----------------------------
// Wishbone types, address map and register offsets of the peripheral bus
// Referenced by scoped names from the decoder, the slaves and the top level
//----------------------------
package soc_bus_pkg;

	// Plain bus vectors
	typedef logic [31:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	typedef logic [3:0]  wb_sel_t;

	// Region field is adr[31:17], register index is adr[3:2]
	typedef logic [14:0] region_t;
	typedef logic [1:0]  reg_idx_t;

	// One classic request, master to slave
	typedef struct packed {
		wb_adr_t adr;
		wb_dat_t dat;
		wb_sel_t sel;
		logic    we;
		logic    cyc;
		logic    stb;
	} wb_req_t;

	// One response, slave to master
	typedef struct packed {
		wb_dat_t dat;
		logic    ack;
	} wb_rsp_t;

	//----------------------------
	// Address map
	//----------------------------
	localparam region_t REGION_TIMER = 15'h7001;
	localparam region_t REGION_GPIO  = 15'h7002;

	// GPIO register indices
	localparam reg_idx_t GPIO_REG_IN   = 2'd0;
	localparam reg_idx_t GPIO_REG_OUT  = 2'd1;
	localparam reg_idx_t GPIO_REG_MASK = 2'd2;

	// Timer register indices
	localparam reg_idx_t TMR_REG_CTRL = 2'd0;
	localparam reg_idx_t TMR_REG_CMP  = 2'd1;
	localparam reg_idx_t TMR_REG_CNT  = 2'd2;

	// Timer control bits
	localparam int TMR_CTRL_EN   = 0;
	localparam int TMR_CTRL_AUTO = 1;
	localparam int TMR_CTRL_PEND = 2;

	// Byte-lane merge of a write into an existing word
	function automatic wb_dat_t wb_merge(wb_dat_t old_dat, wb_dat_t new_dat, wb_sel_t sel);
		wb_dat_t res;
		res = old_dat;
		for (int i = 0; i < 4; i++)
		begin
			if (sel[i])
			begin
				res[8*i +: 8] = new_dat[8*i +: 8];
			end
		end
		return res;
	endfunction

endpackage
